/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/lsu_request_skid.sv
hdl/lsu_store_align.sv
hdl/lsu_load_align.sv
hdl/lsu_writeback.sv
hdl/lsu_bus_fsm.sv
hdl/lsu_top.sv
tb/lsu_tb.sv

/* tb/lsu_tb.sv */
// testbench for lsu_top that runs random operations against a memory responder and a model
`timescale 1ns/1ps
module lsu_tb;

  localparam int CYCLE_LIMIT = 60 * 5 * 20 + 100;
  localparam int STIM = 0;
  localparam int RSP  = 1;
  localparam int K_NONE       = 0;
  localparam int K_ALIGNED    = 1;
  localparam int K_MISALIGNED = 2;
  localparam int K_ANYLOAD    = 3;
  localparam int K_STORE      = 4;

  typedef struct packed {
    logic [1:0]  op;
    logic [1:0]  size;
    logic        sgn;
    logic [31:0] addr;
    logic [31:0] sdata;
    logic [31:0] src2;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        reg_en;
    logic [1:0]  sel;
  } op_t;

  logic                  clock;
  logic                  reset;
  logic                  req_valid_i;
  lsu_pkg::mem_op_e      req_op_i;
  lsu_pkg::mem_size_e    req_size_i;
  logic                  req_signed_i;
  logic [31:0]           req_addr_i;
  logic [31:0]           req_store_data_i;
  logic [31:0]           req_src2_i;
  logic [31:0]           req_pc_i;
  logic [4:0]            req_rd_i;
  logic                  req_reg_en_i;
  lsu_pkg::wb_sel_e      req_wb_sel_i;
  logic                  req_ready_o;
  logic                  mem_ar_valid_o;
  logic [31:0]           mem_ar_addr_o;
  logic                  mem_ar_ready_i;
  logic                  mem_r_valid_i;
  logic [63:0]           mem_r_data_i;
  logic                  mem_aw_valid_o;
  logic [31:0]           mem_aw_addr_o;
  logic [63:0]           mem_w_data_o;
  logic [7:0]            mem_w_strb_o;
  logic                  mem_aw_ready_i;
  logic                  mem_b_valid_i;
  logic                  wb_valid_o;
  logic [31:0]           wb_data_o;
  logic [4:0]            wb_rd_o;
  logic                  wb_reg_en_o;
  logic [31:0]           wb_pc_o;

  logic [15:0] lfsr_st [0:1];
  logic [7:0]  mem_model [0:255];
  logic [7:0]  ref_mem [0:255];
  op_t         exp_q[$];
  int          errors = 0;
  int          ops_done = 0;
  int          tests = 0;
  int          test_err_start = 0;
  int          test_ops_start = 0;
  int          rd_count = 0;
  int          wr_count = 0;
  int          cycles = 0;

  lsu_top #(.ADDR_W(32)) dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // 16-bit fibonacci lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int src, input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_st[src][15] ^ lfsr_st[src][13] ^ lfsr_st[src][12] ^ lfsr_st[src][10];
      lfsr_st[src] = {lfsr_st[src][14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int size_bytes(input logic [1:0] size);
    if (size == lsu_pkg::SIZE_BYTE) return 1;
    if (size == lsu_pkg::SIZE_HALF) return 2;
    return 4;
  endfunction

  // the bytes of the access run past the end of the addressed word
  function automatic logic crosses_word(input op_t o);
    return (int'(o.addr[1:0]) + size_bytes(o.size)) > 4;
  endfunction

  // little endian bytes from the model memory before extension
  function automatic logic [31:0] load_value(input op_t o);
    logic [31:0] v;
    int          n;
    int          k;
    n = size_bytes(o.size);
    v = '0;
    for (k = 0; k < n; k++) begin
      v[8*k +: 8] = ref_mem[(o.addr[7:0] + k) % 256];
    end
    if (o.sgn && n < 4 && v[8*n-1]) begin
      v = v | ~((32'd1 << (8 * n)) - 32'd1);
    end
    return v;
  endfunction

  function automatic logic [31:0] expected_data(input op_t o);
    case (o.sel)
      lsu_pkg::WB_ALU:  return o.addr;
      lsu_pkg::WB_LOAD: return load_value(o);
      lsu_pkg::WB_PC4:  return o.pc + 32'd4;
      default:          return o.src2;
    endcase
  endfunction

  function automatic logic [63:0] read_dword(input logic [31:0] a);
    logic [63:0] d;
    int          k;
    for (k = 0; k < 8; k++) begin
      d[8*k +: 8] = mem_model[{a[7:3], 3'b000} + k];
    end
    return d;
  endfunction

  function automatic op_t rand_op(input int kind);
    op_t        o;
    logic [1:0] sz;
    o.src2   = rand_bits(STIM, 32);
    o.sdata  = rand_bits(STIM, 32);
    o.pc     = {rand_bits(STIM, 30), 2'b00};
    o.rd     = rand_bits(STIM, 5);
    o.reg_en = rand_bits(STIM, 1);
    o.sgn    = rand_bits(STIM, 1);
    sz       = rand_bits(STIM, 2);
    o.size   = (sz == 2'd3) ? 2'd2 : sz;
    o.addr   = rand_bits(STIM, 8);
    o.op     = lsu_pkg::OP_LOAD;
    o.sel    = lsu_pkg::WB_LOAD;
    if (kind == K_NONE) begin
      o.op   = lsu_pkg::OP_NONE;
      o.sel  = rand_bits(STIM, 2);
      o.addr = rand_bits(STIM, 32);
    end else if (kind == K_MISALIGNED) begin
      if (o.size == lsu_pkg::SIZE_BYTE) o.size = lsu_pkg::SIZE_WORD;
      if (o.size == lsu_pkg::SIZE_HALF || o.addr[1:0] == 2'd0) o.addr[0] = 1'b1;
    end else if (kind == K_ALIGNED || kind == K_STORE) begin
      if (o.size == lsu_pkg::SIZE_HALF) o.addr[0] = 1'b0;
      if (o.size == lsu_pkg::SIZE_WORD) o.addr[1:0] = 2'b00;
      if (kind == K_STORE) begin
        o.op  = lsu_pkg::OP_STORE;
        o.sel = rand_bits(STIM, 2);
      end
    end
    return o;
  endfunction

  task automatic send_op(input op_t o);
    req_valid_i      = 1'b1;
    req_op_i         = lsu_pkg::mem_op_e'(o.op);
    req_size_i       = lsu_pkg::mem_size_e'(o.size);
    req_signed_i     = o.sgn;
    req_addr_i       = o.addr;
    req_store_data_i = o.sdata;
    req_src2_i       = o.src2;
    req_pc_i         = o.pc;
    req_rd_i         = o.rd;
    req_reg_en_i     = o.reg_en;
    req_wb_sel_i     = lsu_pkg::wb_sel_e'(o.sel);
    @(posedge clock);
    while (!req_ready_o) @(posedge clock);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clock);
    #1;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #1;
    end
    #1;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d operations, %0d errors", tests, name,
             ops_done - test_ops_start, errors - test_err_start);
    test_err_start = errors;
    test_ops_start = ops_done;
  endtask

  // read port with random ready and response delays of 0 to 3 cycles
  initial begin : read_responder
    logic [31:0] a;
    int          d;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_data_i   = '0;
    forever begin
      @(posedge clock);
      #2;
      mem_r_valid_i = 1'b0;
      if (!reset && mem_ar_valid_o === 1'b1) begin
        d = rand_bits(RSP, 2);
        repeat (d) begin
          @(posedge clock);
          #2;
        end
        a = mem_ar_addr_o;
        if (exp_q.size() == 0 || exp_q[0].op != lsu_pkg::OP_LOAD) begin
          $display("read request at %0t while no load is in progress", $time);
          errors++;
        end else if (a !== exp_q[0].addr + 32'(4 * rd_count)) begin
          $display("error t=%0t mem_ar_addr_o: got %h expected %h", $time, a,
                   exp_q[0].addr + 32'(4 * rd_count));
          errors++;
        end
        mem_ar_ready_i = 1'b1;
        @(posedge clock);
        #2;
        mem_ar_ready_i = 1'b0;
        d = rand_bits(RSP, 2);
        repeat (d) begin
          @(posedge clock);
          #2;
        end
        mem_r_data_i  = read_dword(a);
        mem_r_valid_i = 1'b1;
        rd_count++;
      end
    end
  end

  initial begin : write_responder
    op_t o;
    int  d;
    int  k;
    mem_aw_ready_i = 1'b0;
    mem_b_valid_i  = 1'b0;
    forever begin
      @(posedge clock);
      #2;
      mem_b_valid_i = 1'b0;
      if (!reset && mem_aw_valid_o === 1'b1) begin
        d = rand_bits(RSP, 2);
        repeat (d) begin
          @(posedge clock);
          #2;
        end
        if (exp_q.size() == 0 || exp_q[0].op != lsu_pkg::OP_STORE) begin
          $display("write request at %0t while no store is in progress", $time);
          errors++;
        end else begin
          o = exp_q[0];
          if (mem_aw_addr_o !== o.addr) begin
            $display("error t=%0t mem_aw_addr_o: got %h expected %h", $time,
                     mem_aw_addr_o, o.addr);
            errors++;
          end
          if (mem_w_strb_o !== 8'(((1 << size_bytes(o.size)) - 1) << o.addr[2:0])) begin
            $display("error t=%0t mem_w_strb_o: got %b expected %b", $time, mem_w_strb_o,
                     8'(((1 << size_bytes(o.size)) - 1) << o.addr[2:0]));
            errors++;
          end
          for (k = 0; k < size_bytes(o.size); k++) begin
            if (mem_w_data_o[8*(o.addr[2:0]+k) +: 8] !== o.sdata[8*k +: 8]) begin
              $display("error t=%0t mem_w_data_o: got %h expected byte %0d = %h", $time,
                       mem_w_data_o, o.addr[2:0] + k, o.sdata[8*k +: 8]);
              errors++;
            end
          end
        end
        // the responder memory follows the strobe as driven
        for (k = 0; k < 8; k++) begin
          if (mem_w_strb_o[k]) mem_model[{mem_aw_addr_o[7:3], 3'b000} + k] =
            mem_w_data_o[8*k +: 8];
        end
        mem_aw_ready_i = 1'b1;
        wr_count++;
        @(posedge clock);
        #2;
        mem_aw_ready_i = 1'b0;
        d = rand_bits(RSP, 2);
        repeat (d) begin
          @(posedge clock);
          #2;
        end
        mem_b_valid_i = 1'b1;
      end
    end
  end

  // transfers enter the model and writebacks leave it in order
  always @(posedge clock) begin
    op_t         o;
    logic [31:0] exp_data;
    int          k;
    if (!reset) begin
      if (req_ready_o === 1'b0 && exp_q.size() != 2) begin
        $display("req_ready_o low at %0t with %0d operations outstanding", $time,
                 exp_q.size());
        errors++;
      end
      if (wb_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("writeback pulse at %0t with no operation outstanding", $time);
          errors++;
        end else begin
          o = exp_q.pop_front();
          exp_data = expected_data(o);
          if (wb_rd_o !== o.rd) begin
            $display("error t=%0t wb_rd_o: got %h expected %h", $time, wb_rd_o, o.rd);
            errors++;
          end
          if (wb_reg_en_o !== o.reg_en) begin
            $display("error t=%0t wb_reg_en_o: got %b expected %b", $time, wb_reg_en_o,
                     o.reg_en);
            errors++;
          end
          if (wb_pc_o !== o.pc) begin
            $display("error t=%0t wb_pc_o: got %h expected %h", $time, wb_pc_o, o.pc);
            errors++;
          end
          // load data on a non-load is left undefined
          if ((o.sel != lsu_pkg::WB_LOAD || o.op == lsu_pkg::OP_LOAD) &&
              wb_data_o !== exp_data) begin
            $display("error t=%0t wb_data_o: got %h expected %h", $time, wb_data_o, exp_data);
            errors++;
          end
          if (rd_count != ((o.op == lsu_pkg::OP_LOAD) ? (crosses_word(o) ? 2 : 1) : 0)) begin
            $display("operation at address %h issued %0d read requests", o.addr, rd_count);
            errors++;
          end
          if (wr_count != ((o.op == lsu_pkg::OP_STORE) ? 1 : 0)) begin
            $display("operation at address %h issued %0d write requests", o.addr, wr_count);
            errors++;
          end
          if (o.op == lsu_pkg::OP_STORE) begin
            for (k = 0; k < size_bytes(o.size); k++) begin
              ref_mem[(o.addr[7:0] + k) % 256] = o.sdata[8*k +: 8];
            end
          end
          rd_count = 0;
          wr_count = 0;
          ops_done++;
        end
      end
      if (req_valid_i && req_ready_o) begin
        o = '{op: req_op_i, size: req_size_i, sgn: req_signed_i, addr: req_addr_i,
              sdata: req_store_data_i, src2: req_src2_i, pc: req_pc_i, rd: req_rd_i,
              reg_en: req_reg_en_i, sel: req_wb_sel_i};
        exp_q.push_back(o);
      end
    end
  end

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d operations outstanding", cycles,
             exp_q.size());
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    op_t        o;
    op_t        l;
    int         i;
    logic [7:0] b;
    lfsr_st[STIM]    = 16'd16871;
    lfsr_st[RSP]     = 16'd16871;
    reset            = 1'b1;
    req_valid_i      = 1'b0;
    req_op_i         = lsu_pkg::OP_NONE;
    req_size_i       = lsu_pkg::SIZE_BYTE;
    req_signed_i     = 1'b0;
    req_addr_i       = '0;
    req_store_data_i = '0;
    req_src2_i       = '0;
    req_pc_i         = '0;
    req_rd_i         = '0;
    req_reg_en_i     = 1'b0;
    req_wb_sel_i     = lsu_pkg::WB_ALU;
    for (i = 0; i < 256; i++) begin
      b = rand_bits(STIM, 8);
      mem_model[i] = b;
      ref_mem[i]   = b;
    end
    // 8 cycles of reset and one more cycle checked
    for (i = 1; i <= 9; i++) begin
      @(posedge clock);
      #1;
      if (wb_valid_o !== 1'b0 || mem_ar_valid_o !== 1'b0 || mem_aw_valid_o !== 1'b0) begin
        $display("error t=%0t wb/ar/aw valid: got %b%b%b expected 000", $time, wb_valid_o,
                 mem_ar_valid_o, mem_aw_valid_o);
        errors++;
      end
      if (req_ready_o !== 1'b1) begin
        $display("error t=%0t req_ready_o: got %b expected 1", $time, req_ready_o);
        errors++;
      end
      #1;
      if (i == 8) reset = 1'b0;
    end
    finish_test("reset");

    for (i = 0; i < 60; i++) begin
      o = rand_op(K_NONE);
      if (i < 4) o.sel = i;
      send_op(o);
      wait_idle();
    end
    finish_test("pass-through");

    for (i = 0; i < 60; i++) begin
      send_op(rand_op(K_ALIGNED));
      wait_idle();
    end
    finish_test("aligned loads");

    for (i = 0; i < 60; i++) begin
      o = rand_op(K_MISALIGNED);
      // halfword at offset 1 stays within one word
      if (i < 4) begin
        o.size      = lsu_pkg::SIZE_HALF;
        o.addr[1:0] = 2'd1;
      end
      send_op(o);
      wait_idle();
    end
    finish_test("misaligned loads");

    for (i = 0; i < 30; i++) begin
      o = rand_op(K_STORE);
      send_op(o);
      wait_idle();
      l     = rand_op(K_ALIGNED);
      l.addr = o.addr;
      l.size = o.size;
      send_op(l);
      wait_idle();
    end
    finish_test("stores");

    for (i = 0; i < 60; i++) begin
      case (rand_bits(STIM, 2))
        2'd0:    o = rand_op(K_NONE);
        2'd3:    o = rand_op(K_STORE);
        default: o = rand_op(K_ANYLOAD);
      endcase
      send_op(o);
      if (rand_bits(STIM, 2) == 2'd0) begin
        @(posedge clock);
        #2;
      end
    end
    wait_idle();
    finish_test("back-pressure mix");

    $display("%0d tests, %0d operations checked, %0d errors", tests, ops_done, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* hdl/lsu_top.sv */
// load/store stage top level, connects execute requests to the memory bus and register writeback
`timescale 1ns/1ps
module lsu_top #(
  parameter int ADDR_W = 32
) (
  input  logic                          clock,
  input  logic                          reset,
  // request from execute
  input  logic                          req_valid_i,
  input  lsu_pkg::mem_op_e              req_op_i,
  input  lsu_pkg::mem_size_e            req_size_i,
  input  logic                          req_signed_i,
  input  logic [ADDR_W-1:0]             req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]      req_store_data_i,
  input  logic [lsu_pkg::XLEN-1:0]      req_src2_i,
  input  logic [ADDR_W-1:0]             req_pc_i,
  input  logic [4:0]                    req_rd_i,
  input  logic                          req_reg_en_i,
  input  lsu_pkg::wb_sel_e              req_wb_sel_i,
  output logic                          req_ready_o,
  // memory bus
  output logic                          mem_ar_valid_o,
  output logic [ADDR_W-1:0]             mem_ar_addr_o,
  input  logic                          mem_ar_ready_i,
  input  logic                          mem_r_valid_i,
  input  logic [lsu_pkg::BUS_W-1:0]     mem_r_data_i,
  output logic                          mem_aw_valid_o,
  output logic [ADDR_W-1:0]             mem_aw_addr_o,
  output logic [lsu_pkg::BUS_W-1:0]     mem_w_data_o,
  output logic [lsu_pkg::STRB_W-1:0]    mem_w_strb_o,
  input  logic                          mem_aw_ready_i,
  input  logic                          mem_b_valid_i,
  // register writeback
  output logic                          wb_valid_o,
  output logic [lsu_pkg::XLEN-1:0]      wb_data_o,
  output logic [4:0]                    wb_rd_o,
  output logic                          wb_reg_en_o,
  output logic [ADDR_W-1:0]             wb_pc_o
);

  logic                          cur_valid;
  lsu_pkg::mem_op_e              cur_op;
  lsu_pkg::mem_size_e            cur_size;
  logic                          cur_signed;
  logic [ADDR_W-1:0]             cur_addr;
  logic [lsu_pkg::XLEN-1:0]      cur_store_data;
  logic [lsu_pkg::XLEN-1:0]      cur_src2;
  logic [ADDR_W-1:0]             cur_pc;
  logic [4:0]                    cur_rd;
  logic                          cur_reg_en;
  lsu_pkg::wb_sel_e              cur_wb_sel;
  logic                          accept;
  logic                          done;
  logic [lsu_pkg::BUS_W-1:0]     st_data;
  logic [lsu_pkg::STRB_W-1:0]    st_strb;
  logic                          beat_valid;
  logic                          beat_lane;
  logic                          beat_second;
  logic [1:0]                    ld_offset;
  lsu_pkg::mem_size_e            ld_size;
  logic                          ld_signed;
  logic [lsu_pkg::XLEN-1:0]      load_data;

  lsu_request_skid #(.ADDR_W(ADDR_W)) u_skid (
    .clock, .reset, .req_valid_i, .req_op_i, .req_size_i, .req_signed_i, .req_addr_i,
    .req_store_data_i, .req_src2_i, .req_pc_i, .req_rd_i, .req_reg_en_i, .req_wb_sel_i,
    .accept_i(accept), .req_ready_o,
    .cur_valid_o(cur_valid), .cur_op_o(cur_op), .cur_size_o(cur_size),
    .cur_signed_o(cur_signed), .cur_addr_o(cur_addr), .cur_store_data_o(cur_store_data),
    .cur_src2_o(cur_src2), .cur_pc_o(cur_pc), .cur_rd_o(cur_rd),
    .cur_reg_en_o(cur_reg_en), .cur_wb_sel_o(cur_wb_sel)
  );

  lsu_store_align u_store_align (
    .addr_i(cur_addr[2:0]), .size_i(cur_size), .data_i(cur_store_data),
    .data_o(st_data), .strb_o(st_strb)
  );

  lsu_bus_fsm #(.ADDR_W(ADDR_W)) u_bus_fsm (
    .clock, .reset, .cur_valid_i(cur_valid), .cur_op_i(cur_op), .cur_size_i(cur_size),
    .cur_signed_i(cur_signed), .cur_addr_i(cur_addr), .st_data_i(st_data),
    .st_strb_i(st_strb), .accept_o(accept),
    .mem_ar_valid_o, .mem_ar_addr_o, .mem_ar_ready_i, .mem_r_valid_i,
    .mem_aw_valid_o, .mem_aw_addr_o, .mem_w_data_o, .mem_w_strb_o, .mem_aw_ready_i,
    .mem_b_valid_i, .beat_valid_o(beat_valid), .beat_lane_o(beat_lane),
    .beat_second_o(beat_second), .ld_offset_o(ld_offset), .ld_size_o(ld_size),
    .ld_signed_o(ld_signed), .done_o(done)
  );

  lsu_load_align u_load_align (
    .clock, .reset, .rdata_i(mem_r_data_i), .beat_valid_i(beat_valid),
    .beat_lane_i(beat_lane), .beat_second_i(beat_second), .offset_i(ld_offset),
    .size_i(ld_size), .signed_i(ld_signed), .load_data_o(load_data)
  );

  lsu_writeback #(.ADDR_W(ADDR_W)) u_writeback (
    .clock, .reset, .accept_i(accept), .pc_i(cur_pc), .rd_i(cur_rd),
    .reg_en_i(cur_reg_en), .result_i(cur_addr), .src2_i(cur_src2), .sel_i(cur_wb_sel),
    .load_data_i(load_data), .done_i(done), .wb_valid_o, .wb_data_o, .wb_rd_o,
    .wb_reg_en_o, .wb_pc_o
  );

endmodule

/* hdl/lsu_bus_fsm.sv */
// memory bus controller that issues the reads and writes of one operation and flags its end
`timescale 1ns/1ps
module lsu_bus_fsm #(
  parameter int ADDR_W = 32
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         cur_valid_i,
  input  lsu_pkg::mem_op_e             cur_op_i,
  input  lsu_pkg::mem_size_e           cur_size_i,
  input  logic                         cur_signed_i,
  input  logic [ADDR_W-1:0]            cur_addr_i,
  input  logic [lsu_pkg::BUS_W-1:0]    st_data_i,
  input  logic [lsu_pkg::STRB_W-1:0]   st_strb_i,
  output logic                         accept_o,
  output logic                         mem_ar_valid_o,
  output logic [ADDR_W-1:0]            mem_ar_addr_o,
  input  logic                         mem_ar_ready_i,
  input  logic                         mem_r_valid_i,
  output logic                         mem_aw_valid_o,
  output logic [ADDR_W-1:0]            mem_aw_addr_o,
  output logic [lsu_pkg::BUS_W-1:0]    mem_w_data_o,
  output logic [lsu_pkg::STRB_W-1:0]   mem_w_strb_o,
  input  logic                         mem_aw_ready_i,
  input  logic                         mem_b_valid_i,
  output logic                         beat_valid_o,
  output logic                         beat_lane_o,
  output logic                         beat_second_o,
  output logic [1:0]                   ld_offset_o,
  output lsu_pkg::mem_size_e           ld_size_o,
  output logic                         ld_signed_o,
  output logic                         done_o
);

  lsu_pkg::lsu_state_e state_q;
  logic                split_q;
  logic                second_q;
  logic                split;

  // halfword at offset 3 or unaligned word crosses into the next word
  assign split = (cur_size_i == lsu_pkg::SIZE_HALF && cur_addr_i[1:0] == 2'd3) ||
                 (cur_size_i == lsu_pkg::SIZE_WORD && cur_addr_i[1:0] != 2'd0);

  assign accept_o      = (state_q == lsu_pkg::ST_IDLE) && cur_valid_i;
  assign done_o        = (state_q == lsu_pkg::ST_DONE);
  assign beat_valid_o  = (state_q == lsu_pkg::ST_RD_DATA) && mem_r_valid_i;
  assign beat_lane_o   = mem_ar_addr_o[2];
  assign beat_second_o = second_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q        <= lsu_pkg::ST_IDLE;
      mem_ar_valid_o <= 1'b0;
      mem_aw_valid_o <= 1'b0;
      split_q        <= 1'b0;
      second_q       <= 1'b0;
    end else begin
      case (state_q)
        lsu_pkg::ST_IDLE: begin
          if (accept_o) begin
            split_q     <= split;
            second_q    <= 1'b0;
            ld_offset_o <= cur_addr_i[1:0];
            ld_size_o   <= cur_size_i;
            ld_signed_o <= cur_signed_i;
            case (cur_op_i)
              lsu_pkg::OP_LOAD: begin
                mem_ar_valid_o <= 1'b1;
                mem_ar_addr_o  <= cur_addr_i;
                state_q        <= lsu_pkg::ST_RD_ADDR;
              end
              lsu_pkg::OP_STORE: begin
                mem_aw_valid_o <= 1'b1;
                mem_aw_addr_o  <= cur_addr_i;
                mem_w_data_o   <= st_data_i;
                mem_w_strb_o   <= st_strb_i;
                state_q        <= lsu_pkg::ST_WR_ADDR;
              end
              default: state_q <= lsu_pkg::ST_DONE;
            endcase
          end
        end
        lsu_pkg::ST_RD_ADDR: begin
          if (mem_ar_ready_i) begin
            mem_ar_valid_o <= 1'b0;
            state_q        <= lsu_pkg::ST_RD_DATA;
          end
        end
        lsu_pkg::ST_RD_DATA: begin
          if (mem_r_valid_i) begin
            if (split_q && !second_q) begin
              // second read at the following word
              second_q       <= 1'b1;
              mem_ar_valid_o <= 1'b1;
              mem_ar_addr_o  <= mem_ar_addr_o + ADDR_W'(4);
              state_q        <= lsu_pkg::ST_RD_ADDR;
            end else begin
              state_q <= lsu_pkg::ST_DONE;
            end
          end
        end
        lsu_pkg::ST_WR_ADDR: begin
          if (mem_aw_ready_i) begin
            mem_aw_valid_o <= 1'b0;
            state_q        <= lsu_pkg::ST_WR_RESP;
          end
        end
        lsu_pkg::ST_WR_RESP: begin
          if (mem_b_valid_i) begin
            state_q <= lsu_pkg::ST_DONE;
          end
        end
        default: state_q <= lsu_pkg::ST_IDLE;
      endcase
    end
  end

  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o));

  // the memory answers only a request that is outstanding
  a_r_expected: assert property (@(posedge clock) disable iff (reset)
    mem_r_valid_i |-> state_q == lsu_pkg::ST_RD_DATA);

  a_b_expected: assert property (@(posedge clock) disable iff (reset)
    mem_b_valid_i |-> state_q == lsu_pkg::ST_WR_RESP);

  // the lane strobe relies on naturally aligned stores from execute
  a_store_aligned: assert property (@(posedge clock) disable iff (reset)
    accept_o && cur_op_i == lsu_pkg::OP_STORE |->
      !(cur_size_i == lsu_pkg::SIZE_HALF && cur_addr_i[0]) &&
      !(cur_size_i == lsu_pkg::SIZE_WORD && cur_addr_i[1:0] != 2'd0));

endmodule

/* hdl/lsu_writeback.sv */
// holds the writeback fields of the operation in progress and drives the register write
`timescale 1ns/1ps
module lsu_writeback #(
  parameter int ADDR_W = 32
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        accept_i,
  input  logic [ADDR_W-1:0]           pc_i,
  input  logic [4:0]                  rd_i,
  input  logic                        reg_en_i,
  input  logic [ADDR_W-1:0]           result_i,
  input  logic [lsu_pkg::XLEN-1:0]    src2_i,
  input  lsu_pkg::wb_sel_e            sel_i,
  input  logic [lsu_pkg::XLEN-1:0]    load_data_i,
  input  logic                        done_i,
  output logic                        wb_valid_o,
  output logic [lsu_pkg::XLEN-1:0]    wb_data_o,
  output logic [4:0]                  wb_rd_o,
  output logic                        wb_reg_en_o,
  output logic [ADDR_W-1:0]           wb_pc_o
);

  logic [ADDR_W-1:0]          result_q;
  logic [lsu_pkg::XLEN-1:0]   src2_q;
  lsu_pkg::wb_sel_e           sel_q;
  logic [lsu_pkg::XLEN-1:0]   value;

  // fields stay put until the next accept, which comes after the pulse
  always_ff @(posedge clock) begin
    if (accept_i) begin
      wb_pc_o     <= pc_i;
      wb_rd_o     <= rd_i;
      wb_reg_en_o <= reg_en_i;
      result_q    <= result_i;
      src2_q      <= src2_i;
      sel_q       <= sel_i;
    end
  end

  always_comb begin
    case (sel_q)
      lsu_pkg::WB_LOAD: value = load_data_i;
      lsu_pkg::WB_PC4:  value = lsu_pkg::XLEN'(wb_pc_o) + lsu_pkg::XLEN'(4);
      lsu_pkg::WB_SRC2: value = src2_q;
      default:          value = lsu_pkg::XLEN'(result_q);
    endcase
  end

  always_ff @(posedge clock) begin
    if (done_i) begin
      wb_data_o <= value;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= done_i;
    end
  end

endmodule

/* hdl/lsu_load_align.sv */
// collects the returned read words and forms the extended load value
`timescale 1ns/1ps
module lsu_load_align (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [lsu_pkg::BUS_W-1:0]   rdata_i,
  input  logic                        beat_valid_i,
  input  logic                        beat_lane_i,
  input  logic                        beat_second_i,
  input  logic [1:0]                  offset_i,
  input  lsu_pkg::mem_size_e          size_i,
  input  logic                        signed_i,
  output logic [lsu_pkg::XLEN-1:0]    load_data_o
);

  logic [lsu_pkg::XLEN-1:0]   word0_q;
  logic [lsu_pkg::XLEN-1:0]   word1_q;
  logic                       joined_q;
  logic [lsu_pkg::XLEN-1:0]   lane_word;
  logic [2*lsu_pkg::XLEN-1:0] pair;
  logic [lsu_pkg::XLEN-1:0]   raw;

  // bit 2 of the read address picks the 32-bit half of the doubleword
  assign lane_word = beat_lane_i ? rdata_i[2*lsu_pkg::XLEN-1:lsu_pkg::XLEN]
                                 : rdata_i[lsu_pkg::XLEN-1:0];

  always_ff @(posedge clock) begin
    if (beat_valid_i) begin
      if (beat_second_i) begin
        word1_q <= lane_word;
      end else begin
        word0_q <= lane_word;
      end
    end
  end

  // set once the upper word of a split load is in
  always_ff @(posedge clock) begin
    if (reset) begin
      joined_q <= 1'b0;
    end else if (beat_valid_i) begin
      joined_q <= beat_second_i;
    end
  end

  assign pair = {word1_q, word0_q} >> {offset_i, 3'b000};
  assign raw  = joined_q ? pair[lsu_pkg::XLEN-1:0] : (word0_q >> {offset_i, 3'b000});

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: load_data_o = {{24{signed_i & raw[7]}}, raw[7:0]};
      lsu_pkg::SIZE_HALF: load_data_o = {{16{signed_i & raw[15]}}, raw[15:0]};
      default:            load_data_o = raw;
    endcase
  end

endmodule

/* hdl/lsu_store_align.sv */
// places store data and its byte strobe into the lanes of the 64-bit write bus
`timescale 1ns/1ps
module lsu_store_align (
  input  logic [2:0]                  addr_i,
  input  lsu_pkg::mem_size_e          size_i,
  input  logic [lsu_pkg::XLEN-1:0]    data_i,
  output logic [lsu_pkg::BUS_W-1:0]   data_o,
  output logic [lsu_pkg::STRB_W-1:0]  strb_o
);

  logic [3:0] mask;

  // bytes covered before shifting
  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: mask = 4'b0001;
      lsu_pkg::SIZE_HALF: mask = 4'b0011;
      default:            mask = 4'b1111;
    endcase
  end

  assign data_o = lsu_pkg::BUS_W'(data_i) << {addr_i, 3'b000};
  assign strb_o = lsu_pkg::STRB_W'(mask) << addr_i;

endmodule

/* hdl/lsu_request_skid.sv */
// one-entry skid buffer that presents the waiting operation or else the incoming one
`timescale 1ns/1ps
module lsu_request_skid #(
  parameter int ADDR_W = 32
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        req_valid_i,
  input  lsu_pkg::mem_op_e            req_op_i,
  input  lsu_pkg::mem_size_e          req_size_i,
  input  logic                        req_signed_i,
  input  logic [ADDR_W-1:0]           req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_store_data_i,
  input  logic [lsu_pkg::XLEN-1:0]    req_src2_i,
  input  logic [ADDR_W-1:0]           req_pc_i,
  input  logic [4:0]                  req_rd_i,
  input  logic                        req_reg_en_i,
  input  lsu_pkg::wb_sel_e            req_wb_sel_i,
  input  logic                        accept_i,
  output logic                        req_ready_o,
  output logic                        cur_valid_o,
  output lsu_pkg::mem_op_e            cur_op_o,
  output lsu_pkg::mem_size_e          cur_size_o,
  output logic                        cur_signed_o,
  output logic [ADDR_W-1:0]           cur_addr_o,
  output logic [lsu_pkg::XLEN-1:0]    cur_store_data_o,
  output logic [lsu_pkg::XLEN-1:0]    cur_src2_o,
  output logic [ADDR_W-1:0]           cur_pc_o,
  output logic [4:0]                  cur_rd_o,
  output logic                        cur_reg_en_o,
  output lsu_pkg::wb_sel_e            cur_wb_sel_o
);

  logic                        full_q;
  logic                        arrive;
  lsu_pkg::mem_op_e            op_q;
  lsu_pkg::mem_size_e          size_q;
  logic                        signed_q;
  logic [ADDR_W-1:0]           addr_q;
  logic [lsu_pkg::XLEN-1:0]    store_data_q;
  logic [lsu_pkg::XLEN-1:0]    src2_q;
  logic [ADDR_W-1:0]           pc_q;
  logic [4:0]                  rd_q;
  logic                        reg_en_q;
  lsu_pkg::wb_sel_e            wb_sel_q;

  assign req_ready_o = !full_q;
  assign arrive      = req_valid_i && !full_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (accept_i) begin
      full_q <= 1'b0;
    end else if (arrive) begin
      full_q <= 1'b1;
    end
  end

  // park the operation only when the bus controller is busy
  always_ff @(posedge clock) begin
    if (arrive && !accept_i) begin
      op_q         <= req_op_i;
      size_q       <= req_size_i;
      signed_q     <= req_signed_i;
      addr_q       <= req_addr_i;
      store_data_q <= req_store_data_i;
      src2_q       <= req_src2_i;
      pc_q         <= req_pc_i;
      rd_q         <= req_rd_i;
      reg_en_q     <= req_reg_en_i;
      wb_sel_q     <= req_wb_sel_i;
    end
  end

  assign cur_valid_o      = full_q || req_valid_i;
  assign cur_op_o         = full_q ? op_q         : req_op_i;
  assign cur_size_o       = full_q ? size_q       : req_size_i;
  assign cur_signed_o     = full_q ? signed_q     : req_signed_i;
  assign cur_addr_o       = full_q ? addr_q       : req_addr_i;
  assign cur_store_data_o = full_q ? store_data_q : req_store_data_i;
  assign cur_src2_o       = full_q ? src2_q       : req_src2_i;
  assign cur_pc_o         = full_q ? pc_q         : req_pc_i;
  assign cur_rd_o         = full_q ? rd_q         : req_rd_i;
  assign cur_reg_en_o     = full_q ? reg_en_q     : req_reg_en_i;
  assign cur_wb_sel_o     = full_q ? wb_sel_q     : req_wb_sel_i;

  // a request refused while full is held unchanged until it is taken
  a_req_held: assert property (@(posedge clock) disable iff (reset)
    req_valid_i && !req_ready_o |=>
      req_valid_i && $stable(req_op_i) && $stable(req_addr_i));

endmodule

/* hdl/lsu_pkg.sv */
// shared widths and encodings for the load/store stage, referenced by scoped name
package lsu_pkg;

  // register width and memory bus width
  localparam int XLEN   = 32;
  localparam int BUS_W  = 64;
  localparam int STRB_W = BUS_W / 8;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_LOAD,
    OP_STORE
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  // writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4,
    WB_SRC2
  } wb_sel_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ADDR,
    ST_RD_DATA,
    ST_WR_ADDR,
    ST_WR_RESP,
    ST_DONE
  } lsu_state_e;

endpackage
